// ==== hw/gat_pkg.sv ====
package gat_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Node phases.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef enum logic [1:0] {
    PH_IDLE = 2'd0,
    PH_SPMM = 2'd1,
    PH_DMVM = 2'd2,
    PH_AGGR = 2'd3
  } phase_e;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Data widths.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int VAL_W = 16; // Sparse value, attention value, weight lane.
  localparam int ACC_W = 32; // Lane sum, score, feature word.

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Sticky debug flag positions.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int FLG_SPMM_START = 5;
  localparam int FLG_SPMM_DONE  = 4;
  localparam int FLG_DMVM_START = 3;
  localparam int FLG_DMVM_DONE  = 2;
  localparam int FLG_AGGR_START = 1;
  localparam int FLG_AGGR_DONE  = 0;

endpackage

// ==== hw/phase_if.sv ====
`timescale 1ns/10ps

interface phase_if;

  logic spmm_start;
  logic spmm_done;
  logic dmvm_start;
  logic dmvm_done;
  logic aggr_start;
  logic aggr_done;

  modport ctrl (
    output spmm_start, dmvm_start, aggr_start,
    input  spmm_done, dmvm_done, aggr_done
  );
  modport spmm (input spmm_start, output spmm_done);
  modport dmvm (input dmvm_start, output dmvm_done);
  modport aggr (input aggr_start, output aggr_done);
  modport mon  (
    input spmm_start, spmm_done, dmvm_start, dmvm_done, aggr_start, aggr_done
  );

endinterface

// ==== hw/phase_ctrl.sv ====
`timescale 1ns/10ps

module phase_ctrl import gat_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  start_i,
  output logic  busy_o,
  output logic  done_o,
  phase_if.ctrl ph
);

  phase_e state_q;

  assign busy_o = (state_q != PH_IDLE);

  // Each start pulse is issued on entry to its phase.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q       <= PH_IDLE;
      ph.spmm_start <= 1'b0;
      ph.dmvm_start <= 1'b0;
      ph.aggr_start <= 1'b0;
      done_o        <= 1'b0;
    end else begin
      ph.spmm_start <= 1'b0;
      ph.dmvm_start <= 1'b0;
      ph.aggr_start <= 1'b0;
      done_o        <= 1'b0;
      case (state_q)
        PH_IDLE: begin
          if (start_i) begin
            state_q       <= PH_SPMM;
            ph.spmm_start <= 1'b1;
          end
        end
        PH_SPMM: begin
          if (ph.spmm_done) begin
            state_q       <= PH_DMVM;
            ph.dmvm_start <= 1'b1;
          end
        end
        PH_DMVM: begin
          if (ph.dmvm_done) begin
            state_q       <= PH_AGGR;
            ph.aggr_start <= 1'b1;
          end
        end
        PH_AGGR: begin
          if (ph.aggr_done) begin
            state_q <= PH_IDLE;
            done_o  <= 1'b1; // Node finished.
          end
        end
        default: state_q <= PH_IDLE;
      endcase
    end
  end

endmodule

// ==== hw/spmm_unit.sv ====
`timescale 1ns/10ps

module spmm_unit import gat_pkg::*; #(
  parameter int NUM_LANES = 4,
  parameter int COL_W     = 4
) (
  input  logic                                clk,
  input  logic                                rst_n,
  phase_if.spmm                               ph,
  input  logic                                wgt_we_i,
  input  logic [COL_W-1:0]                    wgt_addr_i,
  input  logic [NUM_LANES-1:0][VAL_W-1:0]     wgt_data_i,
  input  logic                                nz_vld_i,
  input  logic                                nz_last_i,
  input  logic [COL_W-1:0]                    nz_col_i,
  input  logic [VAL_W-1:0]                    nz_val_i,
  output logic [NUM_LANES-1:0][ACC_W-1:0]     lane_sum_o
);

  logic [NUM_LANES-1:0][VAL_W-1:0] wgt_mem [2**COL_W];

  logic                            accept_q;   // Taking sparse entries.
  logic                            rd_vld_q;
  logic                            rd_last_q;
  logic [NUM_LANES-1:0][VAL_W-1:0] rd_row_q;
  logic [VAL_W-1:0]                rd_val_q;
  logic signed [2*VAL_W-1:0]       prod [NUM_LANES];
  logic                            start_ok;
  logic                            nz_take;

  assign start_ok = ph.spmm_start && !accept_q && !rd_vld_q;
  assign nz_take  = nz_vld_i && accept_q;

  always_ff @(posedge clk) begin
    if (wgt_we_i) begin
      wgt_mem[wgt_addr_i] <= wgt_data_i;
    end
    if (nz_take) begin
      rd_row_q <= wgt_mem[nz_col_i]; // Row read, stage one.
      rd_val_q <= nz_val_i;
    end
  end

  always_comb begin
    for (int l = 0; l < NUM_LANES; l++) begin
      prod[l] = $signed(rd_val_q) * $signed(rd_row_q[l]);
    end
  end

  // Accumulate one cycle after the read.
  always_ff @(posedge clk) begin
    for (int l = 0; l < NUM_LANES; l++) begin
      if (start_ok) begin
        lane_sum_o[l] <= '0;
      end else if (rd_vld_q) begin
        lane_sum_o[l] <= lane_sum_o[l] + ACC_W'(prod[l]);
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      accept_q     <= 1'b0;
      rd_vld_q     <= 1'b0;
      rd_last_q    <= 1'b0;
      ph.spmm_done <= 1'b0;
    end else begin
      rd_vld_q     <= nz_take;
      rd_last_q    <= nz_take && nz_last_i;
      ph.spmm_done <= rd_last_q; // Sums settled here.
      if (start_ok) begin
        accept_q <= 1'b1;
      end else if (nz_take && nz_last_i) begin
        accept_q <= 1'b0;
      end
    end
  end

endmodule

// ==== hw/score_unit.sv ====
`timescale 1ns/10ps

module score_unit import gat_pkg::*; #(
  parameter int NUM_LANES = 4
) (
  input  logic                            clk,
  input  logic                            rst_n,
  phase_if.dmvm                           ph,
  input  logic                            att_we_i,
  input  logic [$clog2(NUM_LANES)-1:0]    att_idx_i,
  input  logic [VAL_W-1:0]                att_data_i,
  input  logic [NUM_LANES-1:0][ACC_W-1:0] lane_sum_i,
  output logic [ACC_W-1:0]                score_o
);

  localparam int LANE_W = $clog2(NUM_LANES);

  logic signed [VAL_W-1:0]       att_q [NUM_LANES];
  logic                          run_q;
  logic [LANE_W-1:0]             idx_q;
  logic signed [ACC_W+VAL_W-1:0] prod;

  always_ff @(posedge clk) begin
    if (att_we_i) begin
      att_q[att_idx_i] <= att_data_i;
    end
  end

  assign prod = $signed(lane_sum_i[idx_q]) * att_q[idx_q];

  // One lane per cycle, result kept until the next node.
  always_ff @(posedge clk) begin
    if (ph.dmvm_start && !run_q) begin
      score_o <= '0;
    end else if (run_q) begin
      score_o <= score_o + prod[ACC_W-1:0];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      run_q        <= 1'b0;
      idx_q        <= '0;
      ph.dmvm_done <= 1'b0;
    end else begin
      ph.dmvm_done <= 1'b0;
      if (ph.dmvm_start && !run_q) begin
        run_q <= 1'b1;
        idx_q <= '0;
      end else if (run_q) begin
        idx_q <= idx_q + 1'b1;
        if (idx_q == LANE_W'(NUM_LANES - 1)) begin
          run_q        <= 1'b0;
          ph.dmvm_done <= 1'b1;
        end
      end
    end
  end

endmodule

// ==== hw/aggr_unit.sv ====
`timescale 1ns/10ps

module aggr_unit import gat_pkg::*; #(
  parameter int NUM_LANES = 4,
  parameter int NODE_W    = 8
) (
  input  logic                                  clk,
  input  logic                                  rst_n,
  phase_if.aggr                                 ph,
  input  logic [NUM_LANES-1:0][ACC_W-1:0]       lane_sum_i,
  input  logic [ACC_W-1:0]                      score_i,
  output logic                                  feat_we_o,
  output logic [NODE_W+$clog2(NUM_LANES)-1:0]   feat_addr_o,
  output logic [ACC_W-1:0]                      feat_data_o
);

  localparam int LANE_W = $clog2(NUM_LANES);

  logic [NODE_W-1:0]       node_q;
  logic [LANE_W-1:0]       lane_q;
  logic                    last_lane;
  logic signed [ACC_W-1:0] sum_sel;
  logic signed [ACC_W-1:0] sum_att;

  assign last_lane = (lane_q == LANE_W'(NUM_LANES - 1));

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Write port.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign sum_sel      = lane_sum_i[lane_q];
  assign sum_att      = sum_sel >>> 3;                  // Negative score damps.
  assign feat_data_o  = score_i[ACC_W-1] ? sum_att : sum_sel;
  assign feat_addr_o  = {node_q, lane_q};
  assign ph.aggr_done = feat_we_o && last_lane;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      feat_we_o <= 1'b0;
      lane_q    <= '0;
      node_q    <= '0;
    end else if (!feat_we_o) begin
      if (ph.aggr_start) begin
        feat_we_o <= 1'b1;
        lane_q    <= '0;
      end
    end else if (last_lane) begin
      feat_we_o <= 1'b0;
      lane_q    <= '0;
      node_q    <= node_q + 1'b1; // Next node index.
    end else begin
      lane_q <= lane_q + 1'b1;
    end
  end

endmodule

// ==== hw/debug_monitor.sv ====
`timescale 1ns/10ps

module debug_monitor import gat_pkg::*; #(
  parameter int NUM_LANES  = 4,
  parameter int NODE_W     = 8,
  parameter int PROBE_LANE = 2
) (
  input  logic                            clk,
  input  logic                            rst_n,
  phase_if.mon                            ph,
  input  logic [NUM_LANES-1:0][ACC_W-1:0] lane_sum_i,
  output logic [5:0]                      dbg_flags_o,
  output logic [NODE_W-1:0]               dbg_nodes_o,
  output logic [ACC_W-1:0]                dbg_probe_o
);

  phase_e     seen_q;  // Phase as traced from the pulses.
  logic [5:0] pulses;

  always_comb begin
    pulses                 = '0;
    pulses[FLG_SPMM_START] = ph.spmm_start;
    pulses[FLG_SPMM_DONE]  = ph.spmm_done;
    pulses[FLG_DMVM_START] = ph.dmvm_start;
    pulses[FLG_DMVM_DONE]  = ph.dmvm_done;
    pulses[FLG_AGGR_START] = ph.aggr_start;
    pulses[FLG_AGGR_DONE]  = ph.aggr_done;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      seen_q      <= PH_IDLE;
      dbg_flags_o <= '0;
      dbg_nodes_o <= '0;
      dbg_probe_o <= '0;
    end else begin
      dbg_flags_o <= dbg_flags_o | pulses; // Sticky.
      if (ph.spmm_start) begin
        seen_q <= PH_SPMM;
      end else if (ph.dmvm_start) begin
        seen_q <= PH_DMVM;
      end else if (ph.aggr_start) begin
        seen_q <= PH_AGGR;
      end else if (ph.aggr_done) begin
        seen_q <= PH_IDLE;
      end
      if (ph.spmm_done && seen_q == PH_SPMM) begin
        dbg_probe_o <= lane_sum_i[PROBE_LANE];
      end
      if (ph.aggr_done && seen_q == PH_AGGR) begin
        dbg_nodes_o <= dbg_nodes_o + 1'b1; // Wraps.
      end
    end
  end

endmodule

// ==== hw/gat_top.sv ====
`timescale 1ns/10ps

module gat_top import gat_pkg::*; #(
  parameter int NUM_LANES  = 4,
  parameter int COL_W      = 4,
  parameter int NODE_W     = 8,
  parameter int PROBE_LANE = 2
) (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                start_i,
  output logic                                busy_o,
  output logic                                done_o,
  input  logic                                wgt_we_i,
  input  logic [COL_W-1:0]                    wgt_addr_i,
  input  logic [NUM_LANES-1:0][VAL_W-1:0]     wgt_data_i,
  input  logic                                att_we_i,
  input  logic [$clog2(NUM_LANES)-1:0]        att_idx_i,
  input  logic [VAL_W-1:0]                    att_data_i,
  input  logic                                nz_vld_i,
  input  logic                                nz_last_i,
  input  logic [COL_W-1:0]                    nz_col_i,
  input  logic [VAL_W-1:0]                    nz_val_i,
  output logic                                feat_we_o,
  output logic [NODE_W+$clog2(NUM_LANES)-1:0] feat_addr_o,
  output logic [ACC_W-1:0]                    feat_data_o,
  output logic [5:0]                          dbg_flags_o,
  output logic [NODE_W-1:0]                   dbg_nodes_o,
  output logic [ACC_W-1:0]                    dbg_probe_o
);

  logic [NUM_LANES-1:0][ACC_W-1:0] lane_sum;
  logic [ACC_W-1:0]                score;

  phase_if ph ();

  phase_ctrl u_ctrl (.clk, .rst_n, .start_i, .busy_o, .done_o, .ph(ph.ctrl));

  spmm_unit #(.NUM_LANES(NUM_LANES), .COL_W(COL_W)) u_spmm (
    .clk, .rst_n, .ph(ph.spmm), .wgt_we_i, .wgt_addr_i, .wgt_data_i,
    .nz_vld_i, .nz_last_i, .nz_col_i, .nz_val_i, .lane_sum_o(lane_sum)
  );

  score_unit #(.NUM_LANES(NUM_LANES)) u_score (
    .clk, .rst_n, .ph(ph.dmvm), .att_we_i, .att_idx_i, .att_data_i,
    .lane_sum_i(lane_sum), .score_o(score)
  );

  aggr_unit #(.NUM_LANES(NUM_LANES), .NODE_W(NODE_W)) u_aggr (
    .clk, .rst_n, .ph(ph.aggr), .lane_sum_i(lane_sum), .score_i(score),
    .feat_we_o, .feat_addr_o, .feat_data_o
  );

  debug_monitor #(.NUM_LANES(NUM_LANES), .NODE_W(NODE_W), .PROBE_LANE(PROBE_LANE)) u_mon (
    .clk, .rst_n, .ph(ph.mon), .lane_sum_i(lane_sum),
    .dbg_flags_o, .dbg_nodes_o, .dbg_probe_o
  );

endmodule

// ==== test/gat_asserts.sv ====
`timescale 1ns/10ps

module gat_asserts #(
  parameter int NUM_LANES = 4,
  parameter int NODE_W    = 8
) (
  input logic                                clk,
  input logic                                rst_n,
  input logic                                busy_o,
  input logic                                done_o,
  input logic                                feat_we_o,
  input logic [NODE_W+$clog2(NUM_LANES)-1:0] feat_addr_o,
  input logic                                spmm_start,
  input logic                                spmm_done,
  input logic                                dmvm_start,
  input logic                                dmvm_done,
  input logic                                aggr_start,
  input logic                                aggr_done
);

  localparam int LANE_W = $clog2(NUM_LANES);
  localparam int ADDR_W = NODE_W + LANE_W;

  int fail_cnt = 0;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Phase pulses.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  a_spmm_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    spmm_start |=> !spmm_start)
  else begin
    fail_cnt++;
    $error("spmm_start wider than one cycle");
  end

  a_dmvm_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    dmvm_start |=> !dmvm_start)
  else begin
    fail_cnt++;
    $error("dmvm_start wider than one cycle");
  end

  a_aggr_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    aggr_start |=> !aggr_start)
  else begin
    fail_cnt++;
    $error("aggr_start wider than one cycle");
  end

  // Sparse entries only finish inside a running node.
  a_spmm_done_busy: assert property (@(posedge clk) disable iff (!rst_n)
    spmm_done |-> busy_o)
  else begin
    fail_cnt++;
    $error("spmm_done seen while no node was running");
  end

  // Each phase starts right after the previous one is done.
  a_dmvm_order: assert property (@(posedge clk) disable iff (!rst_n)
    dmvm_start |-> $past(spmm_done))
  else begin
    fail_cnt++;
    $error("dmvm_start without a preceding spmm_done");
  end

  a_aggr_order: assert property (@(posedge clk) disable iff (!rst_n)
    aggr_start |-> $past(dmvm_done))
  else begin
    fail_cnt++;
    $error("aggr_start without a preceding dmvm_done");
  end

  a_done_order: assert property (@(posedge clk) disable iff (!rst_n)
    done_o |-> $past(aggr_done) && !busy_o)
  else begin
    fail_cnt++;
    $error("done_o without a preceding aggr_done");
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Feature write burst.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  a_burst_first: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(feat_we_o) |-> feat_addr_o[LANE_W-1:0] == '0)
  else begin
    fail_cnt++;
    $error("Write burst does not start at lane 0");
  end

  a_burst_step: assert property (@(posedge clk) disable iff (!rst_n)
    feat_we_o && $past(feat_we_o) |-> feat_addr_o == ADDR_W'($past(feat_addr_o) + 1))
  else begin
    fail_cnt++;
    $error("Write addresses are not consecutive");
  end

  // Burst ends on the last lane and done_o follows one cycle later.
  a_burst_end: assert property (@(posedge clk) disable iff (!rst_n)
    $fell(feat_we_o) |-> done_o && $past(feat_addr_o[LANE_W-1:0]) == LANE_W'(NUM_LANES - 1))
  else begin
    fail_cnt++;
    $error("Write burst length or done_o timing wrong");
  end

endmodule

// ==== test/gat_tb.sv ====
`timescale 1ns/10ps

module gat_tb import gat_pkg::*; ();

  localparam int NUM_LANES  = 4;
  localparam int COL_W      = 4;
  localparam int NODE_W     = 8;
  localparam int PROBE_LANE = 2;
  localparam int LANE_W     = $clog2(NUM_LANES);
  localparam int NUM_NODES  = 12;
  localparam int WATCH_CYC  = NUM_NODES * 40 + 2**COL_W + NUM_NODES * NUM_LANES + 40;

  logic                            clk = 1'b0;
  logic                            rst_n;
  logic                            start_i;
  logic                            busy_o;
  logic                            done_o;
  logic                            wgt_we_i;
  logic [COL_W-1:0]                wgt_addr_i;
  logic [NUM_LANES-1:0][VAL_W-1:0] wgt_data_i;
  logic                            att_we_i;
  logic [LANE_W-1:0]               att_idx_i;
  logic [VAL_W-1:0]                att_data_i;
  logic                            nz_vld_i;
  logic                            nz_last_i;
  logic [COL_W-1:0]                nz_col_i;
  logic [VAL_W-1:0]                nz_val_i;
  logic                            feat_we_o;
  logic [NODE_W+LANE_W-1:0]        feat_addr_o;
  logic [ACC_W-1:0]                feat_data_o;
  logic [5:0]                      dbg_flags_o;
  logic [NODE_W-1:0]               dbg_nodes_o;
  logic [ACC_W-1:0]                dbg_probe_o;

  integer                   seed      = 32'h1f05_cd1a;
  int                       errors    = 0;
  int                       done_cnt  = 0;
  int                       node_cnt  = 0;
  int                       neg_nodes = 0;
  int                       pos_nodes = 0;
  logic signed [VAL_W-1:0]  wgt [2**COL_W][NUM_LANES]; // Model copy of the weights.
  logic signed [VAL_W-1:0]  att [NUM_LANES];
  logic [NODE_W+LANE_W-1:0] exp_addr [$];
  logic [ACC_W-1:0]         exp_data [$];

  gat_top #(
    .NUM_LANES(NUM_LANES), .COL_W(COL_W), .NODE_W(NODE_W), .PROBE_LANE(PROBE_LANE)
  ) UUT (.*);

  bind gat_top gat_asserts #(.NUM_LANES(NUM_LANES), .NODE_W(NODE_W)) u_asserts (
    .clk, .rst_n, .busy_o, .done_o, .feat_we_o, .feat_addr_o,
    .spmm_start(ph.spmm_start), .spmm_done(ph.spmm_done),
    .dmvm_start(ph.dmvm_start), .dmvm_done(ph.dmvm_done),
    .aggr_start(ph.aggr_start), .aggr_done(ph.aggr_done)
  );

  always #2 clk = ~clk;

  task automatic tick();
    @(posedge clk);
    #1; // Drive point.
  endtask

  task automatic check_val(input string name, input logic [ACC_W-1:0] got,
                           input logic [ACC_W-1:0] exp);
    assert (got === exp) else begin
      errors++;
      $display("ERR %s got %h expected %h", name, got, exp);
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Stimulus.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic load_weights();
    for (int r = 0; r < 2**COL_W; r++) begin
      for (int l = 0; l < NUM_LANES; l++) begin
        wgt[r][l]     = VAL_W'($random(seed));
        wgt_data_i[l] = wgt[r][l];
      end
      wgt_we_i   = 1'b1;
      wgt_addr_i = COL_W'(r);
      tick();
    end
    wgt_we_i = 1'b0;
  endtask

  // Mode 1 forces all attention values positive, mode 2 negative.
  task automatic load_att(input int mode);
    for (int l = 0; l < NUM_LANES; l++) begin
      att[l] = VAL_W'($random(seed));
      if (mode == 1) att[l][VAL_W-1] = 1'b0;
      if (mode == 2) att[l][VAL_W-1] = 1'b1;
      att_we_i   = 1'b1;
      att_idx_i  = LANE_W'(l);
      att_data_i = att[l];
      tick();
    end
    att_we_i = 1'b0;
  endtask

  // Sparse entries while idle must leave no trace.
  task automatic idle_strobes();
    nz_vld_i  = 1'b1;
    nz_last_i = 1'b1;
    nz_col_i  = COL_W'($random(seed));
    nz_val_i  = VAL_W'($random(seed));
    tick();
    nz_vld_i  = 1'b0;
    nz_last_i = 1'b0;
  endtask

  task automatic run_node(input int mode, input bit poke);
    int                      n_nz;
    int                      col [6];
    logic signed [VAL_W-1:0] val [6];
    logic signed [ACC_W-1:0] sums [NUM_LANES];
    logic signed [ACC_W-1:0] score;
    load_att(mode);
    n_nz = 1 + ({$random(seed)} % 6);
    for (int l = 0; l < NUM_LANES; l++) sums[l] = '0;
    for (int e = 0; e < n_nz; e++) begin
      col[e] = {$random(seed)} % (2**COL_W);
      val[e] = VAL_W'($random(seed));
      for (int l = 0; l < NUM_LANES; l++) begin
        sums[l] = sums[l] + val[e] * wgt[col[e]][l];
      end
    end
    score = '0;
    for (int l = 0; l < NUM_LANES; l++) begin
      score = score + ACC_W'(longint'(sums[l]) * longint'(att[l]));
    end
    if (score < 0) neg_nodes++;
    else pos_nodes++;
    for (int l = 0; l < NUM_LANES; l++) begin
      exp_addr.push_back({NODE_W'(node_cnt), LANE_W'(l)});
      exp_data.push_back(score < 0 ? sums[l] >>> 3 : sums[l]);
    end
    node_cnt++;
    start_i = 1'b1;
    tick();
    start_i = 1'b0;
    tick();                          // SPMM takes entries from here.
    for (int e = 0; e < n_nz; e++) begin
      nz_vld_i  = 1'b1;
      nz_last_i = (e == n_nz - 1);
      nz_col_i  = COL_W'(col[e]);
      nz_val_i  = val[e];
      if (poke && e == 0) start_i = 1'b1; // Ignored while busy.
      tick();
      nz_vld_i  = 1'b0;
      nz_last_i = 1'b0;
      start_i   = 1'b0;
      if ({$random(seed)} % 3 == 0) tick();
    end
    while (!done_o) tick();
    @(negedge clk);
    #1;
    check_val("dbg_probe_o", dbg_probe_o, sums[PROBE_LANE]);
    check_val("dbg_flags_o", ACC_W'(dbg_flags_o), ACC_W'(6'h3f));
    check_val("dbg_nodes_o", ACC_W'(dbg_nodes_o), ACC_W'(node_cnt));
    check_val("done_o count", ACC_W'(done_cnt), ACC_W'(node_cnt));
    tick();
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Feature port and done counter.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always @(negedge clk) begin
    if (rst_n && done_o) done_cnt++;
    if (rst_n && feat_we_o) begin
      if (exp_addr.size() == 0) begin
        errors++;
        $display("Feature write seen when none was expected");
      end else begin
        check_val("feat_addr_o", ACC_W'(feat_addr_o), ACC_W'(exp_addr.pop_front()));
        check_val("feat_data_o", feat_data_o, exp_data.pop_front());
      end
    end
  end

  initial begin
    repeat (WATCH_CYC) @(posedge clk);
    $display("Watchdog expired before all nodes finished");
    $display("Test failed");
    $finish;
  end

  initial begin
    rst_n      = 1'b0;
    start_i    = 1'b0;
    wgt_we_i   = 1'b0;
    wgt_addr_i = '0;
    wgt_data_i = '0;
    att_we_i   = 1'b0;
    att_idx_i  = '0;
    att_data_i = '0;
    nz_vld_i   = 1'b0;
    nz_last_i  = 1'b0;
    nz_col_i   = '0;
    nz_val_i   = '0;
    repeat (4) @(posedge clk);
    #1 rst_n = 1'b1;
    check_val("busy_o", ACC_W'(busy_o), '0);
    check_val("done_o", ACC_W'(done_o), '0);
    check_val("feat_we_o", ACC_W'(feat_we_o), '0);
    check_val("dbg_flags_o", ACC_W'(dbg_flags_o), '0);
    idle_strobes();
    load_weights();
    for (int n = 0; n < NUM_NODES; n++) begin
      run_node(n == 0 ? 1 : (n == 1 ? 2 : 0), (n % 4) == 3);
      if (n % 3 == 1) idle_strobes();
      repeat ({$random(seed)} % 3) tick();
    end
    repeat (3) tick();
    if (exp_addr.size() != 0) begin
      errors++;
      $display("Some expected feature writes never appeared");
    end
    if (neg_nodes == 0 || pos_nodes == 0) begin
      errors++;
      $display("Scores of only one sign were produced");
    end
    $display("Checks done: %0d testbench errors, %0d assertion failures, %0d nodes",
             errors, UUT.u_asserts.fail_cnt, done_cnt);
    if (errors == 0 && UUT.u_asserts.fail_cnt == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== build.f ====
hw/gat_pkg.sv
hw/phase_if.sv
hw/phase_ctrl.sv
hw/spmm_unit.sv
hw/score_unit.sv
hw/aggr_unit.sv
hw/debug_monitor.sv
hw/gat_top.sv
test/gat_asserts.sv
test/gat_tb.sv

// ==== run.sh ====
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal -f build.f --top-module gat_tb -o gat_sim \
  && ./obj_dir/gat_sim +verilator+error+limit+100 | tee /dev/stderr \
  | grep -q "Test completed successfully" \
  && echo "Simulation passed" \
  || { echo "Simulation did not pass"; exit 1; }
